// File: vlog.f
src/lora_cfg_pkg.sv
src/self_check_timer.sv
src/cmd_parser.sv
src/reply_sequencer.sv
src/lora_cfg_top.sv
testbench/tb_lora_cfg.sv

// File: testbench/tb_lora_cfg.sv
`timescale 1ns/100ps

module tb_lora_cfg;

    localparam int self_check_cycles = 16;
    localparam int num_cmds          = 80;
    // Reset command with its check, or a config reply with the longest tx_complete wait
    localparam int longest_cmd_cycles = 3 * 2 + 2 * 6 + 8 + 4 + self_check_cycles;
    // Garbage bytes and idle gap before each command
    localparam int between_cycles     = 2 * 2 + 3;
    localparam int timeout_cycles     = num_cmds * (longest_cmd_cycles + between_cycles) * 2 + 50;

    logic       mode3_clk;
    logic       rst_n;
    logic       m0;
    logic       m1;
    logic       rx_valid;
    logic [7:0] rx_data;
    logic       tx_complete;
    logic       tx_use;
    logic [7:0] tx_data;
    logic [7:0] uart_cfg;
    logic       aux;

    integer     seed;
    int         cycle_count = 0;
    // Model of head, addh, addl, sped, chan, option
    logic [7:0] model_cfg [0:5];
    logic [7:0] exp_q [$];

    lora_cfg_top #(
        .self_check_cycles(self_check_cycles)
    ) dut0 (
        .mode3_clk  (mode3_clk),
        .rst_n      (rst_n),
        .m0         (m0),
        .m1         (m1),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .tx_complete(tx_complete),
        .tx_use     (tx_use),
        .tx_data    (tx_data),
        .uart_cfg   (uart_cfg),
        .aux        (aux)
    );

    initial begin
        mode3_clk = 1'b0;
        forever #50 mode3_clk = ~mode3_clk;
    end

    always @(posedge mode3_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("TESTS FAILED");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "simulation stopped on first mismatch");
        end
    endtask

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        b = $random(seed);
        return b;
    endfunction

    // Random byte that never starts a command
    function automatic logic [7:0] garbage_byte();
        logic [7:0] b;
        b = rand_byte();
        if (b >= 8'hC0 && b <= 8'hC4) begin
            b = b ^ 8'h10;
        end
        return b;
    endfunction

    // One-cycle strobe that returns just after the edge taking the byte
    task automatic send_rx(input logic [7:0] b);
        @(posedge mode3_clk);
        rx_valid <= 1'b1;
        rx_data  <= b;
        @(posedge mode3_clk);
        rx_valid <= 1'b0;
    endtask

    task automatic send_three(input logic [7:0] code);
        repeat (3) send_rx(code);
    endtask

    // Nothing may happen on the outputs
    task automatic idle_gap(input int n);
        repeat (n) begin
            @(negedge mode3_clk);
            check_value("tx_use", 1'b0, tx_use);
            check_value("aux", 1'b1, aux);
        end
    endtask

    task automatic check_reply();
        logic [7:0] exp_b;
        int         wait_n;
        // Request cycle, then one strobe every other cycle
        @(negedge mode3_clk);
        check_value("tx_use", 1'b0, tx_use);
        while (exp_q.size() > 0) begin
            exp_b = exp_q.pop_front();
            @(negedge mode3_clk);
            check_value("tx_use", 1'b1, tx_use);
            check_value("tx_data", exp_b, tx_data);
            @(negedge mode3_clk);
            check_value("tx_use", 1'b0, tx_use);
        end
        wait_n = 1 + rand_below(8);
        repeat (wait_n) begin
            @(negedge mode3_clk);
            check_value("tx_use", 1'b0, tx_use);
        end
        @(posedge mode3_clk);
        tx_complete <= 1'b1;
        @(posedge mode3_clk);
        tx_complete <= 1'b0;
        idle_gap(1);
    endtask

    task automatic run_load();
        logic [7:0] b;
        int         i;
        b = rand_below(2) ? 8'hC2 : 8'hC0;
        send_rx(b);
        model_cfg[0] = b;
        for (i = 1; i < 6; i++) begin
            b = rand_byte();
            send_rx(b);
            model_cfg[i] = b;
        end
        @(negedge mode3_clk);
        check_value("uart_cfg", model_cfg[3], uart_cfg);
        check_value("tx_use", 1'b0, tx_use);
    endtask

    task automatic run_ret_config();
        int i;
        send_three(8'hC1);
        for (i = 0; i < 6; i++) begin
            exp_q.push_back(model_cfg[i]);
        end
        check_reply();
    endtask

    task automatic run_ret_version();
        send_three(8'hC3);
        exp_q.push_back(8'hC3);
        exp_q.push_back(8'h32);
        exp_q.push_back(8'h27);
        exp_q.push_back(8'h02);
        check_reply();
    endtask

    task automatic run_reset();
        send_three(8'hC4);
        @(negedge mode3_clk);
        check_value("aux", 1'b1, aux);
        repeat (self_check_cycles) begin
            @(negedge mode3_clk);
            check_value("aux", 1'b0, aux);
            check_value("tx_use", 1'b0, tx_use);
        end
        @(negedge mode3_clk);
        check_value("aux", 1'b1, aux);
    endtask

    // Three-byte command with a wrong second or third byte
    task automatic run_broken();
        logic [7:0] code;
        logic [7:0] wrong;
        case (rand_below(3))
            0:       code = 8'hC1;
            1:       code = 8'hC3;
            default: code = 8'hC4;
        endcase
        // A load header as the wrong byte must not start a load
        wrong = rand_below(2) ? 8'hC0 : rand_byte();
        if (wrong == code) begin
            wrong = wrong ^ 8'h01;
        end
        send_rx(code);
        if (rand_below(2)) begin
            send_rx(code);
        end
        send_rx(wrong);
        // These would fill the registers if the parser had left idle
        repeat (5) send_rx(garbage_byte());
        idle_gap(4);
        check_value("uart_cfg", model_cfg[3], uart_cfg);
    endtask

    // Full command while not in mode 3
    task automatic run_mode_off();
        int pins;
        pins = rand_below(3);
        @(posedge mode3_clk);
        m0 <= (pins == 1);
        m1 <= (pins == 0);
        case (rand_below(3))
            0: begin
                send_rx(8'hC0);
                repeat (5) send_rx(rand_byte());
            end
            1:       send_three(8'hC1);
            default: send_three(8'hC4);
        endcase
        idle_gap(4);
        check_value("uart_cfg", model_cfg[3], uart_cfg);
        @(posedge mode3_clk);
        m0 <= 1'b1;
        m1 <= 1'b1;
    endtask

    initial begin
        int kind;
        int n;
        seed        = 32'ha9fa;
        rst_n       = 1'b0;
        m0          = 1'b0;
        m1          = 1'b0;
        rx_valid    = 1'b0;
        rx_data     = 8'h00;
        tx_complete = 1'b0;
        model_cfg   = '{8'h00, 8'h00, 8'h00, 8'h18, 8'h00, 8'h00};

        repeat (5) @(posedge mode3_clk);
        rst_n <= 1'b1;
        m0    <= 1'b1;
        m1    <= 1'b1;
        @(negedge mode3_clk);
        check_value("uart_cfg", 8'h18, uart_cfg);
        check_value("aux", 1'b1, aux);
        check_value("tx_use", 1'b0, tx_use);

        for (int i = 0; i < num_cmds; i++) begin
            // Every kind once first, then random
            kind = (i < 6) ? i : rand_below(6);
            n = rand_below(3);
            repeat (n) send_rx(garbage_byte());
            idle_gap(rand_below(4));
            case (kind)
                0:       run_load();
                1:       run_ret_config();
                2:       run_ret_version();
                3:       run_reset();
                4:       run_broken();
                default: run_mode_off();
            endcase
        end

        idle_gap(2);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: src/lora_cfg_top.sv
`timescale 1ns/100ps

module lora_cfg_top import lora_cfg_pkg::*; #(
    parameter int self_check_cycles = 10000
) (
    input  logic      mode3_clk,
    input  logic      rst_n,
    input  logic      m0,
    input  logic      m1,
    input  logic      rx_valid,
    input  cfg_byte_t rx_data,
    input  logic      tx_complete,
    output logic      tx_use,
    output cfg_byte_t tx_data,
    output cfg_byte_t uart_cfg,
    output logic      aux
);

    logic        mode3;
    cfg_byte_t   head;
    cfg_byte_t   addh;
    cfg_byte_t   addl;
    cfg_byte_t   sped;
    cfg_byte_t   chan;
    cfg_byte_t   option;
    logic        req_valid;
    reply_kind_t req_kind;
    logic        busy;

    // Programming mode needs both pins high
    assign mode3    = m0 & m1;
    assign uart_cfg = sped;

    cmd_parser parser0 (
        .mode3_clk(mode3_clk),
        .rst_n    (rst_n),
        .mode3    (mode3),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .busy     (busy),
        .head     (head),
        .addh     (addh),
        .addl     (addl),
        .sped     (sped),
        .chan     (chan),
        .option   (option),
        .req_valid(req_valid),
        .req_kind (req_kind)
    );

    reply_sequencer #(
        .self_check_cycles(self_check_cycles)
    ) sequencer0 (
        .mode3_clk  (mode3_clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_kind   (req_kind),
        .head       (head),
        .addh       (addh),
        .addl       (addl),
        .sped       (sped),
        .chan       (chan),
        .option     (option),
        .tx_complete(tx_complete),
        .busy       (busy),
        .tx_use     (tx_use),
        .tx_data    (tx_data),
        .aux        (aux)
    );

endmodule

// File: src/reply_sequencer.sv
`timescale 1ns/100ps

module reply_sequencer import lora_cfg_pkg::*; #(
    parameter int self_check_cycles = 10000
) (
    input  logic        mode3_clk,
    input  logic        rst_n,
    input  logic        req_valid,
    input  reply_kind_t req_kind,
    input  cfg_byte_t   head,
    input  cfg_byte_t   addh,
    input  cfg_byte_t   addl,
    input  cfg_byte_t   sped,
    input  cfg_byte_t   chan,
    input  cfg_byte_t   option,
    input  logic        tx_complete,
    output logic        busy,
    output logic        tx_use,
    output cfg_byte_t   tx_data,
    output logic        aux
);

    seq_state_t  state;
    reply_kind_t cur_kind;
    logic [2:0]  byte_idx;
    logic [2:0]  reply_len;
    logic        last_byte;

    // Byte that goes out on the next strobe
    reply_kind_t sel_kind;
    logic [2:0]  sel_idx;
    cfg_byte_t   sel_byte;

    logic        check_start;
    logic        check_done;

    assign busy        = (state != sq_idle);
    assign last_byte   = (byte_idx == reply_len - 3'd1);
    assign check_start = (state == sq_idle) & req_valid & (req_kind == reply_reset);

    always_comb begin
        if (state == sq_idle) begin
            sel_kind = req_kind;
            sel_idx  = 3'd0;
        end else begin
            sel_kind = cur_kind;
            sel_idx  = byte_idx + 3'd1;
        end
        if (sel_kind == reply_version) begin
            sel_byte = version_bytes[sel_idx[1:0]];
        end else begin
            case (sel_idx)
                3'd0:    sel_byte = head;
                3'd1:    sel_byte = addh;
                3'd2:    sel_byte = addl;
                3'd3:    sel_byte = sped;
                3'd4:    sel_byte = chan;
                default: sel_byte = option;
            endcase
        end
    end

    always_ff @(posedge mode3_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= sq_idle;
            cur_kind  <= reply_config;
            byte_idx  <= '0;
            reply_len <= '0;
            tx_use    <= 1'b0;
            tx_data   <= '0;
            aux       <= 1'b1;
        end else begin
            case (state)
                sq_idle: begin
                    if (req_valid) begin
                        cur_kind <= req_kind;
                        byte_idx <= '0;
                        if (req_kind == reply_reset) begin
                            aux   <= 1'b0;
                            state <= sq_self_check;
                        end else begin
                            reply_len <= (req_kind == reply_version) ? 3'd4 : 3'd6;
                            tx_use    <= 1'b1;
                            tx_data   <= sel_byte;
                            state     <= sq_send_byte;
                        end
                    end
                end
                sq_send_byte: begin
                    tx_use <= 1'b0;
                    if (last_byte) begin
                        state <= sq_wait_tx_done;
                    end else begin
                        state <= sq_gap;
                    end
                end
                sq_gap: begin
                    byte_idx <= sel_idx;
                    tx_use   <= 1'b1;
                    tx_data  <= sel_byte;
                    state    <= sq_send_byte;
                end
                // Host UART drains its queue
                sq_wait_tx_done: begin
                    if (tx_complete) begin
                        state <= sq_idle;
                    end
                end
                sq_self_check: begin
                    if (check_done) begin
                        aux   <= 1'b1;
                        state <= sq_idle;
                    end
                end
                default: state <= sq_idle;
            endcase
        end
    end

    self_check_timer #(
        .self_check_cycles(self_check_cycles)
    ) check_timer (
        .mode3_clk(mode3_clk),
        .rst_n    (rst_n),
        .start    (check_start),
        .done     (check_done)
    );

    // Each byte gets a gap cycle after it and no request lands meanwhile
    a_tx_use_pulse: assert property (
        @(posedge mode3_clk) disable iff (!rst_n)
        tx_use |-> !req_valid ##1 !tx_use
    );

endmodule

// File: src/cmd_parser.sv
`timescale 1ns/100ps

module cmd_parser import lora_cfg_pkg::*; (
    input  logic        mode3_clk,
    input  logic        rst_n,
    input  logic        mode3,
    input  logic        rx_valid,
    input  cfg_byte_t   rx_data,
    input  logic        busy,
    output cfg_byte_t   head,
    output cfg_byte_t   addh,
    output cfg_byte_t   addl,
    output cfg_byte_t   sped,
    output cfg_byte_t   chan,
    output cfg_byte_t   option,
    output logic        req_valid,
    output reply_kind_t req_kind
);

    parser_state_t state;
    // Code of the three-byte command being matched
    cfg_byte_t     cmd_code;
    logic          byte_take;
    logic          code_match;

    // Bytes only count in programming mode
    assign byte_take  = mode3 & rx_valid;
    assign code_match = (rx_data == cmd_code);

    function automatic reply_kind_t code_to_kind(input cfg_byte_t code);
        reply_kind_t kind;
        case (code)
            cmd_ret_config:  kind = reply_config;
            cmd_ret_version: kind = reply_version;
            default:         kind = reply_reset;
        endcase
        return kind;
    endfunction

    always_ff @(posedge mode3_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ps_idle;
            cmd_code  <= '0;
            head      <= init_head;
            addh      <= init_addh;
            addl      <= init_addl;
            sped      <= init_sped;
            chan      <= init_chan;
            option    <= init_option;
            req_valid <= 1'b0;
            req_kind  <= reply_config;
        end else begin
            req_valid <= 1'b0;
            if (byte_take) begin
                case (state)
                    ps_idle: begin
                        case (rx_data)
                            head_load_save, head_load_temp: begin
                                head  <= rx_data;
                                state <= ps_read_addh;
                            end
                            cmd_ret_config, cmd_ret_version, cmd_reset: begin
                                cmd_code <= rx_data;
                                state    <= ps_cmd_second;
                            end
                            // Anything else is noise
                            default: state <= ps_idle;
                        endcase
                    end
                    ps_read_addh: begin
                        addh  <= rx_data;
                        state <= ps_read_addl;
                    end
                    ps_read_addl: begin
                        addl  <= rx_data;
                        state <= ps_read_sped;
                    end
                    ps_read_sped: begin
                        sped  <= rx_data;
                        state <= ps_read_chan;
                    end
                    ps_read_chan: begin
                        chan  <= rx_data;
                        state <= ps_read_option;
                    end
                    ps_read_option: begin
                        option <= rx_data;
                        state  <= ps_idle;
                    end
                    ps_cmd_second: begin
                        if (code_match) begin
                            state <= ps_cmd_third;
                        end else begin
                            state <= ps_idle;
                        end
                    end
                    ps_cmd_third: begin
                        state <= ps_idle;
                        // Dropped if a reply is still running
                        if (code_match && !busy) begin
                            req_valid <= 1'b1;
                            req_kind  <= code_to_kind(cmd_code);
                        end
                    end
                    default: state <= ps_idle;
                endcase
            end
        end
    end

    // Requests are single pulses and the sequencer takes each one
    a_req_pulse: assert property (
        @(posedge mode3_clk) disable iff (!rst_n)
        req_valid |=> !req_valid && busy
    );

    // Sequencer must be free when a request lands
    a_req_not_busy: assert property (
        @(posedge mode3_clk) disable iff (!rst_n)
        req_valid |-> !busy
    );

endmodule

// File: src/self_check_timer.sv
`timescale 1ns/100ps

module self_check_timer #(
    parameter int self_check_cycles = 10000
) (
    input  logic mode3_clk,
    input  logic rst_n,
    input  logic start,
    output logic done
);

    localparam int cnt_w = $clog2(self_check_cycles + 1);

    logic             active;
    logic [cnt_w-1:0] count;

    always_ff @(posedge mode3_clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            count  <= '0;
        end else if (start) begin
            // Restart also when already counting
            active <= 1'b1;
            count  <= cnt_w'(self_check_cycles - 1);
        end else if (active) begin
            if (count == '0) begin
                active <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // Last cycle of the count
    assign done = active & (count == '0);

    // Sequencer never restarts the check at its end
    a_done_no_start: assert property (
        @(posedge mode3_clk) disable iff (!rst_n)
        !(done && start)
    );

endmodule

// File: src/lora_cfg_pkg.sv
package lora_cfg_pkg;

    // One UART data byte or configuration byte
    typedef logic [7:0] cfg_byte_t;

    // Load headers for saved or temporary settings
    parameter cfg_byte_t head_load_save = 8'hC0;
    parameter cfg_byte_t head_load_temp = 8'hC2;

    // Three-byte commands repeat the same code
    parameter cfg_byte_t cmd_ret_config  = 8'hC1;
    parameter cfg_byte_t cmd_ret_version = 8'hC3;
    parameter cfg_byte_t cmd_reset       = 8'hC4;

    // Version reply in send order
    parameter cfg_byte_t version_bytes [0:3] = '{
        8'hC3,
        8'h32,
        8'h27,
        8'h02
    };

    // Register contents after reset
    parameter cfg_byte_t init_head   = 8'h00;
    parameter cfg_byte_t init_addh   = 8'h00;
    parameter cfg_byte_t init_addl   = 8'h00;
    // 8N1 at 9600 baud
    parameter cfg_byte_t init_sped   = 8'h18;
    parameter cfg_byte_t init_chan   = 8'h00;
    parameter cfg_byte_t init_option = 8'h00;

    // Reply requested from the sequencer
    typedef enum logic [1:0] {
        reply_config,
        reply_version,
        reply_reset
    } reply_kind_t;

    // Command parser FSM
    typedef enum logic [2:0] {
        ps_idle,
        ps_read_addh,
        ps_read_addl,
        ps_read_sped,
        ps_read_chan,
        ps_read_option,
        ps_cmd_second,
        ps_cmd_third
    } parser_state_t;

    // Reply sequencer FSM
    typedef enum logic [2:0] {
        sq_idle,
        sq_send_byte,
        sq_gap,
        sq_wait_tx_done,
        sq_self_check
    } seq_state_t;

endpackage
